// ==== Bender.yml ====
package:
  name: cdc

sources:
  - common/cdc_pkg.sv
  - protocol/frame_parser.sv
  - protocol/command_dispatcher.sv
  - src/pwm_handler.sv
  - src/dsm_handler.sv
  - src/upload_packer.sv
  - src/cdc.sv
  - target: test
    files:
      - tb/cdc_checker.sv
      - tb/cdc_tb.sv

// ==== common/cdc_pkg.sv ====
`default_nettype none

package cdc_pkg;

    // ==============================
    // Basic stream types
    // ==============================
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] len_t;
    typedef logic [15:0] count_t;

    // ==============================
    // Frame headers
    // ==============================
    localparam byte_t DOWN_HDR_H = 8'hAA;
    localparam byte_t DOWN_HDR_L = 8'h55;
    localparam byte_t UP_HDR_H   = 8'hAA;
    localparam byte_t UP_HDR_L   = 8'h44;

    // Payload buffer inside the parser
    localparam int MAX_PAYLOAD    = 64;
    localparam int PAYLOAD_ADDR_W = 6;
    typedef logic [PAYLOAD_ADDR_W-1:0] payload_addr_t;

    // ==============================
    // Handlers
    // ==============================
    localparam int NUM_PWM_CH = 8;
    localparam int NUM_DSM_CH = 8;

    localparam byte_t CMD_PWM = 8'h20;
    localparam byte_t CMD_DSM = 8'h0A;

    // Uplink source tag for DSM replies
    localparam byte_t DSM_SOURCE = 8'h0A;

    // Measurement window in clocks
    localparam int DSM_WINDOW    = 256;
    localparam int DSM_REPLY_LEN = 2;

endpackage

`default_nettype wire

// ==== flist.f ====
common/cdc_pkg.sv
protocol/frame_parser.sv
protocol/command_dispatcher.sv
src/pwm_handler.sv
src/dsm_handler.sv
src/upload_packer.sv
src/cdc.sv
tb/cdc_checker.sv
tb/cdc_tb.sv

// ==== protocol/command_dispatcher.sv ====
`default_nettype none

module command_dispatcher (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         parse_done,
    input  wire cdc_pkg::byte_t         cmd,
    input  wire cdc_pkg::len_t          len,
    output cdc_pkg::payload_addr_t      payload_addr,
    input  wire cdc_pkg::byte_t         payload_data,
    input  wire                         handlers_ready,
    output cdc_pkg::byte_t              cmd_type,
    output cdc_pkg::byte_t              cmd_data,
    output cdc_pkg::payload_addr_t      cmd_index,
    output logic                        cmd_start,
    output logic                        cmd_data_valid,
    output logic                        cmd_done,
    output logic                        led_out
);
    import cdc_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT,
        S_SEND,
        S_DONE
    } disp_state_t;

    disp_state_t   state;
    len_t          len_q;
    payload_addr_t rd_addr;
    logic          last_read;

    assign payload_addr = rd_addr;
    assign last_read    = (len_t'(rd_addr) == len_q - 1'b1);

    // Buffer data lags the address by one cycle, same as cmd_data_valid
    assign cmd_data = payload_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= S_IDLE;
            rd_addr        <= '0;
            cmd_index      <= '0;
            cmd_start      <= 1'b0;
            cmd_data_valid <= 1'b0;
            cmd_done       <= 1'b0;
            led_out        <= 1'b0;
        end else begin
            cmd_start      <= 1'b0;
            cmd_data_valid <= 1'b0;
            cmd_done       <= 1'b0;
            case (state)
                // Frames that arrive while busy are dropped here
                S_IDLE: if (parse_done) state <= S_WAIT;
                S_WAIT: begin
                    if (handlers_ready) begin
                        cmd_start <= 1'b1;
                        led_out   <= ~led_out;
                        rd_addr   <= '0;
                        state     <= (len_q == '0) ? S_DONE : S_SEND;
                    end
                end
                S_SEND: begin
                    cmd_data_valid <= 1'b1;
                    cmd_index      <= rd_addr;
                    rd_addr        <= rd_addr + 1'b1;
                    if (last_read) state <= S_DONE;
                end
                S_DONE: begin
                    cmd_done <= 1'b1;
                    state    <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Hold the frame header for the whole dispatch
    always_ff @(posedge clk) begin
        if (state == S_IDLE && parse_done) begin
            cmd_type <= cmd;
            len_q    <= len;
        end
    end

endmodule

`default_nettype wire

// ==== protocol/frame_parser.sv ====
`default_nettype none

module frame_parser (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire cdc_pkg::byte_t         rx_data,
    input  wire                         rx_strobe,
    input  wire cdc_pkg::payload_addr_t payload_addr,
    output cdc_pkg::byte_t              payload_data,
    output logic                        parse_done,
    output cdc_pkg::byte_t              cmd,
    output cdc_pkg::len_t               len
);
    import cdc_pkg::*;

    typedef enum logic [2:0] {
        S_HDR_H,
        S_HDR_L,
        S_CMD,
        S_LEN_H,
        S_LEN_L,
        S_PAYLOAD,
        S_SUM
    } parse_state_t;

    parse_state_t  state;
    payload_addr_t wr_idx;
    byte_t         sum;
    len_t          rx_len;
    byte_t         mem [MAX_PAYLOAD];

    // Full length once the low byte shows up
    assign rx_len = {len[15:8], rx_data};

    // ==============================
    // Frame state machine
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_HDR_H;
            wr_idx     <= '0;
            parse_done <= 1'b0;
        end else begin
            parse_done <= 1'b0;
            if (rx_strobe) begin
                case (state)
                    S_HDR_H: if (rx_data == DOWN_HDR_H) state <= S_HDR_L;
                    S_HDR_L: begin
                        if (rx_data == DOWN_HDR_L) begin
                            state <= S_CMD;
                        end else if (rx_data != DOWN_HDR_H) begin
                            state <= S_HDR_H;
                        end
                    end
                    S_CMD:   state <= S_LEN_H;
                    S_LEN_H: state <= S_LEN_L;
                    S_LEN_L: begin
                        wr_idx <= '0;
                        // Oversize frames go straight back to hunting
                        if (rx_len > len_t'(MAX_PAYLOAD)) begin
                            state <= S_HDR_H;
                        end else if (rx_len == '0) begin
                            state <= S_SUM;
                        end else begin
                            state <= S_PAYLOAD;
                        end
                    end
                    S_PAYLOAD: begin
                        wr_idx <= wr_idx + 1'b1;
                        if (len_t'(wr_idx) == len - 1'b1) state <= S_SUM;
                    end
                    S_SUM: begin
                        parse_done <= (rx_data == sum);
                        state      <= S_HDR_H;
                    end
                    default: state <= S_HDR_H;
                endcase
            end
        end
    end

    // Command, length and running sum over cmd, length and payload
    always_ff @(posedge clk) begin
        if (rx_strobe) begin
            case (state)
                S_CMD: begin
                    cmd <= rx_data;
                    sum <= rx_data;
                end
                S_LEN_H: begin
                    len[15:8] <= rx_data;
                    sum       <= sum + rx_data;
                end
                S_LEN_L: begin
                    len[7:0] <= rx_data;
                    sum      <= sum + rx_data;
                end
                S_PAYLOAD: begin
                    mem[wr_idx] <= rx_data;
                    sum         <= sum + rx_data;
                end
                default: ;
            endcase
        end
    end

    // Registered read port for the dispatcher
    always_ff @(posedge clk) begin
        payload_data <= mem[payload_addr];
    end

endmodule

`default_nettype wire

// ==== src/cdc.sv ====
`default_nettype none

module cdc (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire cdc_pkg::byte_t               usb_data_in,
    input  wire                               usb_data_valid_in,
    output logic                              led_out,
    output logic [cdc_pkg::NUM_PWM_CH-1:0]    pwm_pins,
    input  wire  [cdc_pkg::NUM_DSM_CH-1:0]    dsm_signal_in,
    output cdc_pkg::byte_t                    usb_upload_data,
    output logic                              usb_upload_valid
);
    import cdc_pkg::*;

    // Host strobe edge detect
    logic          valid_q;
    logic          rx_strobe;

    // Parser to dispatcher
    logic          parse_done;
    byte_t         parsed_cmd;
    len_t          parsed_len;
    payload_addr_t payload_addr;
    byte_t         payload_data;

    // Command bus
    byte_t         cmd_type;
    byte_t         cmd_data;
    payload_addr_t cmd_index;
    logic          cmd_start;
    logic          cmd_data_valid;
    logic          cmd_done;

    logic          pwm_ready;
    logic          dsm_ready;
    logic          handlers_ready;

    // DSM reply into the packer
    byte_t         upload_data;
    logic          upload_valid;
    logic          upload_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= usb_data_valid_in;
        end
    end

    assign rx_strobe = usb_data_valid_in & ~valid_q;

    // PWM never stalls the bus
    assign pwm_ready      = 1'b1;
    assign handlers_ready = pwm_ready & dsm_ready;

    frame_parser u_parser (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx_data      (usb_data_in),
        .rx_strobe    (rx_strobe),
        .payload_addr (payload_addr),
        .payload_data (payload_data),
        .parse_done   (parse_done),
        .cmd          (parsed_cmd),
        .len          (parsed_len)
    );

    command_dispatcher u_dispatcher (
        .clk            (clk),
        .rst_n          (rst_n),
        .parse_done     (parse_done),
        .cmd            (parsed_cmd),
        .len            (parsed_len),
        .payload_addr   (payload_addr),
        .payload_data   (payload_data),
        .handlers_ready (handlers_ready),
        .cmd_type       (cmd_type),
        .cmd_data       (cmd_data),
        .cmd_index      (cmd_index),
        .cmd_start      (cmd_start),
        .cmd_data_valid (cmd_data_valid),
        .cmd_done       (cmd_done),
        .led_out        (led_out)
    );

    pwm_handler u_pwm_handler (
        .clk            (clk),
        .rst_n          (rst_n),
        .cmd_type       (cmd_type),
        .cmd_data       (cmd_data),
        .cmd_index      (cmd_index),
        .cmd_data_valid (cmd_data_valid),
        .cmd_done       (cmd_done),
        .pwm_pins       (pwm_pins)
    );

    dsm_handler u_dsm_handler (
        .clk            (clk),
        .rst_n          (rst_n),
        .cmd_type       (cmd_type),
        .cmd_data       (cmd_data),
        .cmd_index      (cmd_index),
        .cmd_data_valid (cmd_data_valid),
        .cmd_done       (cmd_done),
        .ready          (dsm_ready),
        .dsm_signal_in  (dsm_signal_in),
        .upload_data    (upload_data),
        .upload_valid   (upload_valid),
        .upload_ready   (upload_ready)
    );

    upload_packer u_packer (
        .clk              (clk),
        .rst_n            (rst_n),
        .upload_data      (upload_data),
        .upload_valid     (upload_valid),
        .upload_ready     (upload_ready),
        .usb_upload_data  (usb_upload_data),
        .usb_upload_valid (usb_upload_valid)
    );

endmodule

`default_nettype wire

// ==== src/dsm_handler.sv ====
`default_nettype none

module dsm_handler (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire cdc_pkg::byte_t             cmd_type,
    input  wire cdc_pkg::byte_t             cmd_data,
    input  wire cdc_pkg::payload_addr_t     cmd_index,
    input  wire                             cmd_data_valid,
    input  wire                             cmd_done,
    output logic                            ready,
    input  wire  [cdc_pkg::NUM_DSM_CH-1:0]  dsm_signal_in,
    output cdc_pkg::byte_t                  upload_data,
    output logic                            upload_valid,
    input  wire                             upload_ready
);
    import cdc_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_MEASURE,
        S_SEND_H,
        S_SEND_L
    } dsm_state_t;

    dsm_state_t                    state;
    logic [NUM_DSM_CH-1:0]         sync_q1;
    logic [NUM_DSM_CH-1:0]         sync_q2;
    logic [$clog2(NUM_DSM_CH)-1:0] ch_sel;
    count_t                        win_cnt;
    count_t                        high_cnt;

    // Two-flop synchronizer on the raw inputs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= dsm_signal_in;
            sync_q2 <= sync_q1;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_data_valid && cmd_type == CMD_DSM && cmd_index == 0) begin
            ch_sel <= cmd_data[$clog2(NUM_DSM_CH)-1:0];
        end
    end

    // ==============================
    // Window counter and reply
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            win_cnt  <= '0;
            high_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (cmd_done && cmd_type == CMD_DSM) begin
                        win_cnt  <= '0;
                        high_cnt <= '0;
                        state    <= S_MEASURE;
                    end
                end
                S_MEASURE: begin
                    high_cnt <= high_cnt + count_t'(sync_q2[ch_sel]);
                    win_cnt  <= win_cnt + 1'b1;
                    if (win_cnt == count_t'(DSM_WINDOW - 1)) state <= S_SEND_H;
                end
                S_SEND_H: if (upload_ready) state <= S_SEND_L;
                S_SEND_L: if (upload_ready) state <= S_IDLE;
                default:  state <= S_IDLE;
            endcase
        end
    end

    // Busy from the cycle after cmd_done until the low byte is taken
    assign ready        = (state == S_IDLE);
    assign upload_valid = (state == S_SEND_H) || (state == S_SEND_L);
    assign upload_data  = (state == S_SEND_H) ? high_cnt[15:8] : high_cnt[7:0];

endmodule

`default_nettype wire

// ==== src/pwm_handler.sv ====
`default_nettype none

module pwm_handler (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire cdc_pkg::byte_t             cmd_type,
    input  wire cdc_pkg::byte_t             cmd_data,
    input  wire cdc_pkg::payload_addr_t     cmd_index,
    input  wire                             cmd_data_valid,
    input  wire                             cmd_done,
    output logic [cdc_pkg::NUM_PWM_CH-1:0]  pwm_pins
);
    import cdc_pkg::*;

    byte_t chan_q;
    byte_t duty_q;
    byte_t duty [NUM_PWM_CH];
    byte_t pwm_cnt;

    // Byte 0 picks the channel, byte 1 carries the duty
    always_ff @(posedge clk) begin
        if (cmd_data_valid && cmd_type == CMD_PWM) begin
            if (cmd_index == 0) begin
                chan_q <= cmd_data;
            end else if (cmd_index == 1) begin
                duty_q <= cmd_data;
            end
        end
    end

    // ==============================
    // Duty table and PWM compare
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pwm_cnt  <= '0;
            pwm_pins <= '0;
            for (int i = 0; i < NUM_PWM_CH; i++) begin
                duty[i] <= '0;
            end
        end else begin
            pwm_cnt <= pwm_cnt + 1'b1;
            if (cmd_done && cmd_type == CMD_PWM && chan_q < NUM_PWM_CH) begin
                duty[chan_q[$clog2(NUM_PWM_CH)-1:0]] <= duty_q;
            end
            for (int i = 0; i < NUM_PWM_CH; i++) begin
                pwm_pins[i] <= (pwm_cnt < duty[i]);
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/upload_packer.sv ====
`default_nettype none

module upload_packer (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire cdc_pkg::byte_t upload_data,
    input  wire                 upload_valid,
    output logic                upload_ready,
    output cdc_pkg::byte_t      usb_upload_data,
    output logic                usb_upload_valid
);
    import cdc_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_HDR_L,
        S_SRC,
        S_LEN_H,
        S_LEN_L,
        S_DATA,
        S_SUM
    } pack_state_t;

    pack_state_t state;
    logic        upload_valid_q;
    logic        frame_start;
    len_t        data_cnt;
    byte_t       sum;

    assign frame_start  = upload_valid && !upload_valid_q;
    assign upload_ready = (state == S_DATA);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state            <= S_IDLE;
            upload_valid_q   <= 1'b0;
            usb_upload_valid <= 1'b0;
            data_cnt         <= '0;
        end else begin
            upload_valid_q   <= upload_valid;
            usb_upload_valid <= 1'b1;
            case (state)
                S_IDLE: begin
                    usb_upload_valid <= frame_start;
                    if (frame_start) state <= S_HDR_L;
                end
                S_HDR_L: state <= S_SRC;
                S_SRC:   state <= S_LEN_H;
                S_LEN_H: state <= S_LEN_L;
                S_LEN_L: begin
                    data_cnt <= '0;
                    state    <= S_DATA;
                end
                S_DATA: begin
                    usb_upload_valid <= upload_valid;
                    if (upload_valid) begin
                        data_cnt <= data_cnt + 1'b1;
                        if (data_cnt == len_t'(DSM_REPLY_LEN - 1)) state <= S_SUM;
                    end
                end
                S_SUM:   state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // Output byte and checksum from the source byte on
    always_ff @(posedge clk) begin
        case (state)
            S_IDLE:  usb_upload_data <= UP_HDR_H;
            S_HDR_L: usb_upload_data <= UP_HDR_L;
            S_SRC: begin
                usb_upload_data <= DSM_SOURCE;
                sum             <= DSM_SOURCE;
            end
            S_LEN_H: begin
                usb_upload_data <= byte_t'(DSM_REPLY_LEN >> 8);
                sum             <= sum + byte_t'(DSM_REPLY_LEN >> 8);
            end
            S_LEN_L: begin
                usb_upload_data <= byte_t'(DSM_REPLY_LEN);
                sum             <= sum + byte_t'(DSM_REPLY_LEN);
            end
            S_DATA: begin
                if (upload_valid) begin
                    usb_upload_data <= upload_data;
                    sum             <= sum + upload_data;
                end
            end
            S_SUM:   usb_upload_data <= sum;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== tb/cdc_checker.sv ====
`default_nettype none

module cdc_checker (
    input wire                 clk,
    input wire                 rst_n,
    input wire cdc_pkg::byte_t usb_upload_data,
    input wire                 usb_upload_valid
);
    import cdc_pkg::*;

    // Raised by any failing assertion below
    logic assert_failed = 1'b0;

    // Uplink stays quiet while reset is held
    no_valid_in_reset: assert property (
        @(posedge clk) !rst_n |-> !usb_upload_valid
    ) else begin
        assert_failed = 1'b1;
        $error("usb_upload_valid seen while rst_n is low");
    end

    // Every uplink frame opens with the header byte
    frame_starts_with_hdr: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(usb_upload_valid) |-> usb_upload_data == UP_HDR_H
    ) else begin
        assert_failed = 1'b1;
        $error("first uplink byte after idle is not the header");
    end

    // Five header bytes, two data bytes and the checksum
    eight_byte_burst: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(usb_upload_valid) |-> usb_upload_valid [*8] ##1 !usb_upload_valid
    ) else begin
        assert_failed = 1'b1;
        $error("uplink burst is not eight consecutive valid cycles");
    end

endmodule

`default_nettype wire

// ==== tb/cdc_tb.sv ====
`default_nettype none

module cdc_tb;
    import cdc_pkg::*;

    // Tests need about 3500 cycles, the rest is margin
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int SETTLE_CYCLES  = 300;
    localparam int PWM_PERIOD     = 256;

    logic                  clk;
    logic                  rst_n;
    byte_t                 usb_data_in;
    logic                  usb_data_valid_in;
    logic                  led_out;
    logic [NUM_PWM_CH-1:0] pwm_pins;
    wire  [NUM_DSM_CH-1:0] dsm_signal_in;
    byte_t                 usb_upload_data;
    logic                  usb_upload_valid;

    // DSM input drive, either a level or a 16-cycle square wave
    logic [NUM_DSM_CH-1:0] dsm_level;
    logic                  sq_en;
    logic [2:0]            sq_ch;
    logic [3:0]            sq_phase;

    logic [31:0] lfsr;
    int          cycle_cnt = 0;
    int          led_toggles;
    logic        led_prev;
    int          frames_accepted;
    byte_t       uplink_q[$];
    byte_t       tx_payload[$];
    byte_t       duty_model [NUM_PWM_CH];
    int          high_cnt [NUM_PWM_CH];

    assign dsm_signal_in = sq_en ? ({{(NUM_DSM_CH-1){1'b0}}, sq_phase[3]} << sq_ch)
                                 : dsm_level;

    always #5 clk = ~clk;

    cdc i_cdc (
        .clk               (clk),
        .rst_n             (rst_n),
        .usb_data_in       (usb_data_in),
        .usb_data_valid_in (usb_data_valid_in),
        .led_out           (led_out),
        .pwm_pins          (pwm_pins),
        .dsm_signal_in     (dsm_signal_in),
        .usb_upload_data   (usb_upload_data),
        .usb_upload_valid  (usb_upload_valid)
    );

    bind cdc cdc_checker i_checker (
        .clk              (clk),
        .rst_n            (rst_n),
        .usb_upload_data  (usb_upload_data),
        .usb_upload_valid (usb_upload_valid)
    );

    // ==============================
    // Monitors and watchdog
    // ==============================
    always @(negedge clk) begin
        sq_phase <= sq_phase + 1'b1;
        if (usb_upload_valid) uplink_q.push_back(usb_upload_data);
        if (rst_n && led_out !== led_prev) led_toggles++;
        led_prev <= led_out;
        if (i_cdc.i_checker.assert_failed) begin
            abort_run("An uplink assertion in cdc_checker failed");
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $fatal(1);
        end
    end

    // ==============================
    // Helpers
    // ==============================
    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic send_byte(input byte_t b);
        @(negedge clk);
        usb_data_in       = b;
        usb_data_valid_in = 1'b1;
        @(negedge clk);
        usb_data_valid_in = 1'b0;
    endtask

    // Sum runs over command, length and payload
    task automatic send_frame(input byte_t cmd, input len_t len_field, input bit bad_sum);
        byte_t sum;
        sum = cmd + len_field[15:8] + len_field[7:0];
        foreach (tx_payload[i]) sum += tx_payload[i];
        if (bad_sum) sum = sum + 8'h01;
        send_byte(DOWN_HDR_H);
        send_byte(DOWN_HDR_L);
        send_byte(cmd);
        send_byte(len_field[15:8]);
        send_byte(len_field[7:0]);
        foreach (tx_payload[i]) send_byte(tx_payload[i]);
        send_byte(sum);
    endtask

    task automatic send_pwm(input byte_t ch, input byte_t duty, input bit bad_sum);
        tx_payload.delete();
        tx_payload.push_back(ch);
        tx_payload.push_back(duty);
        send_frame(CMD_PWM, 16'd2, bad_sum);
    endtask

    task automatic send_dsm(input byte_t ch);
        tx_payload.delete();
        tx_payload.push_back(ch);
        send_frame(CMD_DSM, 16'd1, 1'b0);
    endtask

    task automatic wait_led(input int target, input string name);
        int waited;
        waited = 0;
        wait_cycles(1);
        while (led_toggles < target) begin
            wait_cycles(1);
            waited++;
            if (waited > 50) abort_run({name, ": led_out did not toggle after the frame"});
        end
        wait_cycles(8);
        check(name, target, led_toggles);
    endtask

    task automatic wait_uplink(input int n, input string name);
        int waited;
        waited = 0;
        wait_cycles(1);
        while (uplink_q.size() < n) begin
            wait_cycles(1);
            waited++;
            if (waited > DSM_WINDOW + 100) abort_run({name, ": no DSM reply on the uplink"});
        end
    endtask

    // Expected reply built from the uplink frame format
    task automatic check_reply(input string name, input count_t count);
        byte_t exp_b [8];
        byte_t sum;
        exp_b[0] = 8'hAA;
        exp_b[1] = 8'h44;
        exp_b[2] = 8'h0A;
        exp_b[3] = 8'h00;
        exp_b[4] = 8'h02;
        exp_b[5] = count[15:8];
        exp_b[6] = count[7:0];
        sum = '0;
        for (int i = 2; i < 7; i++) sum += exp_b[i];
        exp_b[7] = sum;
        check(name, 8, uplink_q.size());
        for (int i = 0; i < 8; i++) check(name, exp_b[i], uplink_q[i]);
    endtask

    // High time of every pin over one full counter period
    task automatic check_pwm(input string name);
        foreach (high_cnt[i]) high_cnt[i] = 0;
        repeat (PWM_PERIOD) begin
            @(negedge clk);
            for (int i = 0; i < NUM_PWM_CH; i++) begin
                if (pwm_pins[i]) high_cnt[i]++;
            end
        end
        for (int i = 0; i < NUM_PWM_CH; i++) check(name, duty_model[i], high_cnt[i]);
    endtask

    // ==============================
    // Directed tests
    // ==============================
    task automatic test_reset();
        wait_cycles(2);
        check("reset", 0, led_out);
        check("reset", 0, pwm_pins);
        check("reset", 0, usb_upload_valid);
        check("reset", 0, uplink_q.size());
    endtask

    task automatic test_pwm_duty();
        logic [31:0] ch;
        logic [31:0] duty;
        repeat (2) begin
            take_bits(3, ch);
            take_bits(8, duty);
            send_pwm(ch[7:0], duty[7:0], 1'b0);
            frames_accepted++;
            duty_model[ch] = duty[7:0];
            wait_led(frames_accepted, "pwm_duty");
            wait_cycles(SETTLE_CYCLES);
            check_pwm("pwm_duty");
        end
    endtask

    task automatic test_bad_frames();
        logic [31:0] ch;
        take_bits(3, ch);
        send_pwm(ch[7:0], byte_t'(~duty_model[ch]), 1'b1);
        // Length one past the buffer, full body and a good checksum
        tx_payload.delete();
        tx_payload.push_back(ch[7:0]);
        tx_payload.push_back(byte_t'(~duty_model[ch]));
        while (tx_payload.size() < MAX_PAYLOAD + 1) begin
            tx_payload.push_back(8'h11);
        end
        send_frame(CMD_PWM, len_t'(MAX_PAYLOAD + 1), 1'b0);
        wait_cycles(40);
        check("bad_frames", frames_accepted, led_toggles);
        check_pwm("bad_frames");
    endtask

    task automatic test_dsm_constant();
        logic [31:0] ch;
        take_bits(3, ch);
        @(negedge clk);
        dsm_level     = '0;
        dsm_level[ch] = 1'b1;
        wait_cycles(4);
        uplink_q.delete();
        send_dsm(ch[7:0]);
        frames_accepted++;
        wait_led(frames_accepted, "dsm_constant");
        wait_uplink(8, "dsm_constant");
        wait_cycles(4);
        check_reply("dsm_constant", count_t'(DSM_WINDOW));
    endtask

    task automatic test_dsm_square_pwm();
        logic [31:0] ch;
        logic [31:0] pwm_ch;
        logic [31:0] duty;
        int          base;
        take_bits(3, ch);
        take_bits(3, pwm_ch);
        take_bits(8, duty);
        @(negedge clk);
        dsm_level = '0;
        sq_ch     = ch[2:0];
        sq_en     = 1'b1;
        wait_cycles(4);
        uplink_q.delete();
        base = frames_accepted;
        send_dsm(ch[7:0]);
        send_pwm(pwm_ch[7:0], duty[7:0], 1'b0);
        frames_accepted += 2;
        // PWM frame is still held when the reply begins
        wait_uplink(1, "dsm_square_pwm");
        check("dsm_square_pwm", base + 1, led_toggles);
        wait_uplink(8, "dsm_square_pwm");
        wait_cycles(4);
        check_reply("dsm_square_pwm", count_t'(DSM_WINDOW / 2));
        wait_led(frames_accepted, "dsm_square_pwm");
        duty_model[pwm_ch] = duty[7:0];
        wait_cycles(SETTLE_CYCLES);
        check_pwm("dsm_square_pwm");
        @(negedge clk);
        sq_en = 1'b0;
    endtask

    task automatic test_led_count();
        wait_cycles(10);
        check("led_count", frames_accepted, led_toggles);
    endtask

    initial begin
        clk               = 1'b0;
        rst_n             = 1'b0;
        usb_data_in       = '0;
        usb_data_valid_in = 1'b0;
        dsm_level         = '0;
        sq_en             = 1'b0;
        sq_ch             = '0;
        sq_phase          = '0;
        lfsr              = 32'h9d84_5082;
        led_toggles       = 0;
        led_prev          = 1'b0;
        frames_accepted   = 0;
        foreach (duty_model[i]) duty_model[i] = '0;

        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        test_reset();
        test_pwm_duty();
        test_bad_frames();
        test_dsm_constant();
        test_dsm_square_pwm();
        test_led_count();

        if (i_cdc.i_checker.assert_failed) begin
            abort_run("An uplink assertion in cdc_checker failed");
        end else begin
            $display("=== PASS ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
